// File: verilog/mem_if_pkg.sv
package mem_if_pkg;

    // application interface of the memory, one 32-bit beat per data transfer
    localparam int app_addr_w = 30;
    localparam int app_data_w = 32;

    typedef logic [app_addr_w-1:0] app_addr_t;  // beat address
    typedef logic [app_data_w-1:0] app_data_t;

    localparam app_addr_t addr_inc = app_addr_t'(2);  // one 64-bit sample is two beats

    typedef enum logic [2:0] {
        cmd_write = 3'b000,
        cmd_read  = 3'b001
    } app_cmd_e;

    // command plus write data path, as driven by one requester
    typedef struct packed {
        logic      en;
        app_cmd_e  cmd;
        app_addr_t addr;
        logic      wdf_wren;
        logic      wdf_end;   // high beat of the pair
        app_data_t wdf_data;
    } app_req_t;

    // read return, low beat first then high beat with end set
    typedef struct packed {
        logic      valid;
        logic      data_end;
        app_data_t data;
    } app_rsp_t;

endpackage

// File: verilog/capture_pkg.sv
package capture_pkg;

    localparam int sample_w = 64;

    // one ADC sample word as it sits in the pre and post FIFOs
    typedef logic [sample_w-1:0] sample_t;

    // same word split into memory beats, low beat goes first
    typedef struct packed {
        mem_if_pkg::app_data_t hi;
        mem_if_pkg::app_data_t lo;
    } sample_beats_t;

    // writer takes it apart as beats, reader fills beats and reads a word
    typedef union packed {
        sample_t       word;
        sample_beats_t beats;
    } sample_word_u;

endpackage

// File: verilog/sample_writer.sv
module sample_writer #(
    parameter int mem_words = 32
) (
    input  logic                  ui_clk,
    input  logic                  reset,
    input  logic                  capture_go,
    input  logic                  write_done_in,
    input  logic                  app_rdy,
    input  capture_pkg::sample_t  pre_dout,
    input  logic                  pre_empty,
    output logic                  pre_rd,
    output mem_if_pkg::app_req_t  wr_req,
    output logic                  write_done,
    output mem_if_pkg::app_addr_t words_written,
    output logic                  mem_full,
    output logic                  writing
);
    import mem_if_pkg::*;
    import capture_pkg::*;

    localparam app_addr_t top_addr = app_addr_t'(mem_words) * addr_inc;  // beats when full

    typedef enum logic [1:0] {
        s_idle,
        s_wait,
        s_write1,
        s_write2
    } state_e;

    state_e       state;
    state_e       next_state;
    app_addr_t    wr_addr;
    sample_word_u cur_word;   // word popped for the current beat pair
    logic         done_hold;  // capture finished upstream, drain what is left
    logic         finish;
    logic         incr_addr;
    logic         last_slot;

    assign last_slot = (wr_addr + addr_inc == top_addr);
    assign finish = (state == s_wait) && done_hold && pre_empty && ~capture_go;

    always_comb begin
        next_state = state;
        pre_rd = 1'b0;
        incr_addr = 1'b0;
        if (capture_go) begin
            next_state = s_wait;
        end else begin
            case (state)
                s_idle: next_state = s_idle;
                s_wait: begin
                    if (~pre_empty && app_rdy) begin
                        pre_rd = 1'b1;
                        if (~mem_full)
                            next_state = s_write1;  // else word is dropped
                    end else if (finish) begin
                        next_state = s_idle;
                    end
                end
                s_write1: begin
                    if (app_rdy)
                        next_state = s_write2;
                end
                s_write2: begin
                    incr_addr = 1'b1;
                    if (last_slot) begin
                        next_state = s_wait;
                    end else if (~pre_empty && app_rdy) begin
                        pre_rd = 1'b1;  // back to back samples
                        next_state = s_write1;
                    end else begin
                        next_state = s_wait;
                    end
                end
                default: next_state = s_idle;
            endcase
        end
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            state <= s_idle;
            wr_addr <= '0;
            mem_full <= 1'b0;
            done_hold <= 1'b0;
            write_done <= 1'b0;
        end else begin
            state <= next_state;
            write_done <= finish;
            if (capture_go) begin
                wr_addr <= '0;
                mem_full <= 1'b0;
                done_hold <= 1'b0;
            end else begin
                if (incr_addr) begin
                    wr_addr <= wr_addr + addr_inc;
                    if (last_slot)
                        mem_full <= 1'b1;
                end
                if (state == s_idle)
                    done_hold <= 1'b0;
                else if (write_done_in)
                    done_hold <= 1'b1;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (pre_rd)
            cur_word.word <= pre_dout;
        if (finish)
            words_written <= wr_addr / addr_inc;  // samples, capped by the full stop
    end

    always_comb begin
        wr_req.en = (state == s_write1);
        wr_req.cmd = cmd_write;
        wr_req.addr = wr_addr;
        wr_req.wdf_wren = (state == s_write1) || (state == s_write2);
        wr_req.wdf_end = (state == s_write2);
        wr_req.wdf_data = (state == s_write2) ? cur_word.beats.hi : cur_word.beats.lo;
    end

    assign writing = (state != s_idle) || write_done;  // covers the handover cycle

endmodule

// File: verilog/app_mem.sv
module app_mem #(
    parameter int mem_words = 32
) (
    input  logic                 ui_clk,
    input  logic                 reset,
    input  mem_if_pkg::app_req_t wr_req,
    input  mem_if_pkg::app_req_t rd_req,
    output logic                 app_rdy,
    output mem_if_pkg::app_rsp_t rd_rsp
);
    import mem_if_pkg::*;

    localparam int beat_w = $clog2(2 * mem_words);

    app_data_t         mem [2*mem_words];
    logic [beat_w-1:0] wr_idx;
    logic              rd_accept;
    logic              s1_valid;   // low beat due next cycle
    logic              s2_valid;   // high beat due next cycle
    logic [beat_w-1:0] s1_idx;
    logic [beat_w-1:0] s2_idx;
    logic              rsp_valid;
    logic              rsp_end;
    app_data_t         rsp_data;

    // sample addresses are even, the end beat takes the odd slot
    assign wr_idx = {wr_req.addr[beat_w-1:1], wr_req.wdf_end};
    assign rd_accept = app_rdy && rd_req.en && (rd_req.cmd == cmd_read);

    always_ff @(posedge ui_clk) begin
        if (wr_req.wdf_wren)
            mem[wr_idx] <= wr_req.wdf_data;
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            app_rdy <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_end <= 1'b0;
        end else begin
            app_rdy <= 1'b1;  // no calibration, ready right after reset
            s1_valid <= rd_accept;
            s2_valid <= s1_valid;
            rsp_valid <= s1_valid || s2_valid;
            rsp_end <= s2_valid;
        end
    end

    // return path, high beat wins if two requests land back to back
    always_ff @(posedge ui_clk) begin
        s1_idx <= rd_req.addr[beat_w-1:0];
        s2_idx <= {s1_idx[beat_w-1:1], 1'b1};
        rsp_data <= s2_valid ? mem[s2_idx] : mem[s1_idx];
    end

    assign rd_rsp = '{valid: rsp_valid, data_end: rsp_end, data: rsp_data};

endmodule

// File: verilog/sample_reader.sv
module sample_reader (
    input  logic                  ui_clk,
    input  logic                  reset,
    input  logic                  capture_go,
    input  logic                  write_done,
    input  mem_if_pkg::app_addr_t words_written,
    input  logic                  app_rdy,
    input  mem_if_pkg::app_rsp_t  rd_rsp,
    input  logic                  post_prog_full,
    output mem_if_pkg::app_req_t  rd_req,
    output logic                  post_wr,
    output capture_pkg::sample_t  post_din,
    output logic                  reading
);
    import mem_if_pkg::*;
    import capture_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_wait,
        s_read1,
        s_read2,
        s_drain   // last read still in flight
    } state_e;

    state_e       state;
    state_e       next_state;
    app_addr_t    rd_addr;
    app_addr_t    end_addr;
    sample_word_u beat_buf;
    logic         incr_addr;
    logic         at_end;
    logic         end_beat;

    assign at_end = (rd_addr == end_addr);
    assign end_beat = rd_rsp.valid && rd_rsp.data_end;

    always_comb begin
        next_state = state;
        incr_addr = 1'b0;
        if (capture_go) begin
            next_state = s_idle;  // abort readback
        end else begin
            case (state)
                s_idle: begin
                    if (write_done)
                        next_state = s_wait;
                end
                s_wait: begin
                    if (at_end)
                        next_state = s_idle;  // empty capture
                    else if (app_rdy && ~post_prog_full)
                        next_state = s_read1;
                end
                s_read1: begin
                    if (app_rdy) begin
                        incr_addr = 1'b1;
                        next_state = s_read2;
                    end
                end
                s_read2: begin
                    if (at_end)
                        next_state = s_drain;
                    else if (app_rdy && ~post_prog_full)
                        next_state = s_read1;
                    else
                        next_state = s_wait;
                end
                s_drain: begin
                    if (end_beat)
                        next_state = s_idle;
                end
                default: next_state = s_idle;
            endcase
        end
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            state <= s_idle;
            rd_addr <= '0;
            end_addr <= '0;
            post_wr <= 1'b0;
        end else begin
            state <= next_state;
            post_wr <= end_beat && (state != s_idle) && ~capture_go;  // drop stale returns
            if (state == s_idle && write_done) begin
                rd_addr <= '0;
                end_addr <= words_written * addr_inc;
            end else if (incr_addr) begin
                rd_addr <= rd_addr + addr_inc;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (rd_rsp.valid) begin
            if (rd_rsp.data_end)
                beat_buf.beats.hi <= rd_rsp.data;
            else
                beat_buf.beats.lo <= rd_rsp.data;
        end
    end

    assign post_din = beat_buf.word;

    always_comb begin
        rd_req.en = (state == s_read1);
        rd_req.cmd = cmd_read;
        rd_req.addr = rd_addr;
        rd_req.wdf_wren = 1'b0;
        rd_req.wdf_end = 1'b0;
        rd_req.wdf_data = '0;
    end

    assign reading = (state != s_idle) || post_wr;

endmodule

// File: verilog/ddr_capture_top.sv
module ddr_capture_top #(
    parameter int mem_words = 32
) (
    input  logic                 ui_clk,
    input  logic                 reset,
    input  logic                 capture_go,
    input  logic                 write_done_in,
    input  capture_pkg::sample_t pre_dout,
    input  logic                 pre_empty,
    input  logic                 post_prog_full,
    output logic                 pre_rd,
    output logic                 post_wr,
    output capture_pkg::sample_t post_din,
    output logic                 mem_full,
    output logic                 busy
);
    import mem_if_pkg::*;

    app_req_t  wr_req;
    app_req_t  rd_req;
    app_rsp_t  rd_rsp;
    app_addr_t words_written;  // samples stored, handed to the reader
    logic      app_rdy;
    logic      write_done;
    logic      writing;
    logic      reading;

    sample_writer #(
        .mem_words     (mem_words)
    ) u_sample_writer (
        .ui_clk        (ui_clk),
        .reset         (reset),
        .capture_go    (capture_go),
        .write_done_in (write_done_in),
        .app_rdy       (app_rdy),
        .pre_dout      (pre_dout),
        .pre_empty     (pre_empty),
        .pre_rd        (pre_rd),
        .wr_req        (wr_req),
        .write_done    (write_done),
        .words_written (words_written),
        .mem_full      (mem_full),
        .writing       (writing)
    );

    app_mem #(
        .mem_words (mem_words)
    ) u_app_mem (
        .ui_clk    (ui_clk),
        .reset     (reset),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .app_rdy   (app_rdy),
        .rd_rsp    (rd_rsp)
    );

    sample_reader u_sample_reader (
        .ui_clk         (ui_clk),
        .reset          (reset),
        .capture_go     (capture_go),
        .write_done     (write_done),
        .words_written  (words_written),
        .app_rdy        (app_rdy),
        .rd_rsp         (rd_rsp),
        .post_prog_full (post_prog_full),
        .rd_req         (rd_req),
        .post_wr        (post_wr),
        .post_din       (post_din),
        .reading        (reading)
    );

    assign busy = writing | reading;

endmodule

// File: sim/ddr_capture_sva.sv
module ddr_capture_sva (
    input logic                 ui_clk,
    input logic                 reset,
    input mem_if_pkg::app_req_t wr_req,
    input mem_if_pkg::app_req_t rd_req,
    input logic                 app_rdy,
    input mem_if_pkg::app_rsp_t rd_rsp
);
    import mem_if_pkg::*;

    logic rd_issued;
    logic lo_write;
    logic hi_write;

    assign rd_issued = app_rdy && rd_req.en && (rd_req.cmd == cmd_read);
    assign lo_write = wr_req.wdf_wren && !wr_req.wdf_end;
    assign hi_write = wr_req.wdf_wren && wr_req.wdf_end;

    cmd_exclusive: assert property (@(posedge ui_clk) disable iff (reset)
        !(wr_req.en && rd_req.en))
        else $error("write and read requests enabled in the same cycle");

    // beat pair goes out low then high
    hi_after_lo: assert property (@(posedge ui_clk) disable iff (reset)
        hi_write |-> $past(lo_write))
        else $error("high-beat write without a low-beat write before it");

    // low beat one cycle ahead of the end beat
    rd_latency: assert property (@(posedge ui_clk) disable iff (reset)
        $past(rd_issued, 3) |-> rd_rsp.valid && rd_rsp.data_end
                                && $past(rd_rsp.valid && !rd_rsp.data_end))
        else $error("read return did not end three cycles after its request");

endmodule

bind app_mem ddr_capture_sva u_ddr_capture_sva (
    .ui_clk  (ui_clk),
    .reset   (reset),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .app_rdy (app_rdy),
    .rd_rsp  (rd_rsp)
);

// File: sim/tb_ddr_capture.sv
module tb_ddr_capture;
    import capture_pkg::*;

    localparam int mem_words = 8;
    localparam int n_rows = 7;
    localparam int feed_limit = 100;
    localparam int word_limit = 500;
    localparam int idle_limit = 2000;

    // one capture of the table
    typedef struct packed {
        int         count;       // samples queued upstream
        logic       done_late;   // write_done_in after the last sample is queued
        logic [7:0] bp_pattern;  // post_prog_full per 4-cycle slot
        logic       abort;       // abort a readback first
        logic       exp_full;
    } row_t;

    logic    ui_clk;
    logic    reset;
    logic    capture_go;
    logic    write_done_in;
    sample_t pre_dout;
    logic    pre_empty;
    logic    post_prog_full;
    logic    pre_rd;
    logic    post_wr;
    sample_t post_din;
    logic    mem_full;
    logic    busy;

    row_t        rows [n_rows];
    row_t        r;
    sample_t     pre_q[$];   // pre-memory FIFO model
    sample_t     exp_q[$];   // words still due from the post side
    logic [31:0] lfsr;
    logic [31:0] cyc;
    logic [7:0]  bp;
    int          feed_left;
    int          fed;
    int          got;
    int          burst;      // words since post_prog_full last rose
    int          errors;
    int          err_mark;
    int          rows_failed;
    int          n_exp;
    logic        timed_out;

    ddr_capture_top #(
        .mem_words      (mem_words)
    ) u_ddr_capture_top (
        .ui_clk         (ui_clk),
        .reset          (reset),
        .capture_go     (capture_go),
        .write_done_in  (write_done_in),
        .pre_dout       (pre_dout),
        .pre_empty      (pre_empty),
        .post_prog_full (post_prog_full),
        .pre_rd         (pre_rd),
        .post_wr        (post_wr),
        .post_din       (post_din),
        .mem_full       (mem_full),
        .busy           (busy)
    );

    initial begin
        ui_clk = 1'b0;
        forever #50 ui_clk = ~ui_clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic sample_t random_sample();
        sample_t s;
        int      b;
        s = '0;
        for (b = 0; b < sample_w; b++)
            s = {s[sample_w-2:0], next_random_bit()};
        return s;
    endfunction

    task automatic note_timeout(string what, int limit);
        $display("timeout: %s did not happen within %0d cycles", what, limit);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic check_word(sample_t w);
        sample_t e;
        got++;
        if (post_prog_full) begin
            burst++;
            assert (burst <= 3) else begin
                $display("error %0t: %0d words after post_prog_full rose", $time, burst);
                errors++;
            end
        end
        assert (exp_q.size() > 0) else begin
            $display("error %0t: word %h arrived with none expected", $time, w);
            errors++;
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (w == e) else begin
                $display("error %0t: word %0d is %h, expected %h", $time, got, w, e);
                errors++;
            end
        end
    endtask

    // outputs are read right at the edge, inputs follow with nonblocking writes
    task automatic clock_cycle();
        sample_t s;
        logic    nxt_full;
        @(posedge ui_clk);
        cyc = cyc + 1;
        if (pre_rd) begin
            assert (pre_q.size() > 0) else begin
                $display("error %0t: pop from an empty pre-memory FIFO", $time);
                errors++;
            end
            if (pre_q.size() > 0)
                void'(pre_q.pop_front());
        end
        if (post_wr)
            check_word(post_din);
        if (feed_left > 0) begin
            s = random_sample();
            pre_q.push_back(s);
            if (fed < mem_words)
                exp_q.push_back(s);  // extra words are dropped once full
            fed++;
            feed_left--;
        end
        pre_empty <= (pre_q.size() == 0);
        pre_dout <= (pre_q.size() > 0) ? pre_q[0] : '0;
        nxt_full = bp[cyc[4:2]];
        if (nxt_full && !post_prog_full)
            burst = 0;
        post_prog_full <= nxt_full;
    endtask

    task automatic start_capture(int n);
        capture_go <= 1'b1;
        clock_cycle();
        capture_go <= 1'b0;
        exp_q.delete();  // anything left of an aborted readback
        feed_left = n;
        fed = 0;
        got = 0;
    endtask

    task automatic pulse_write_done();
        write_done_in <= 1'b1;
        clock_cycle();
        write_done_in <= 1'b0;
    endtask

    task automatic wait_words(int n);
        int k;
        k = 0;
        while (!timed_out && got < n && k < word_limit) begin
            clock_cycle();
            k++;
        end
        if (!timed_out && k >= word_limit)
            note_timeout("readback words", word_limit);
    endtask

    task automatic wait_feed_done();
        int k;
        k = 0;
        while (!timed_out && feed_left > 0 && k < feed_limit) begin
            clock_cycle();
            k++;
        end
        if (!timed_out && k >= feed_limit)
            note_timeout("sample feed", feed_limit);
    endtask

    task automatic wait_idle();
        int k;
        k = 0;
        while (!timed_out && busy && k < idle_limit) begin
            clock_cycle();
            k++;
        end
        if (!timed_out && k >= idle_limit)
            note_timeout("busy to drop", idle_limit);
    endtask

    initial begin
        reset = 1'b1;
        capture_go = 1'b0;
        write_done_in = 1'b0;
        pre_dout = '0;
        pre_empty = 1'b1;
        post_prog_full = 1'b0;
        lfsr = 32'h228b_454c;
        cyc = '0;
        bp = '0;
        feed_left = 0;
        fed = 0;
        got = 0;
        burst = 0;
        errors = 0;
        rows_failed = 0;
        timed_out = 1'b0;
        rows[0] = '{5, 1'b0, 8'h00, 1'b0, 1'b0};
        rows[1] = '{8, 1'b1, 8'h00, 1'b0, 1'b1};  // exactly full
        rows[2] = '{7, 1'b0, 8'b1100_0110, 1'b0, 1'b0};
        rows[3] = '{12, 1'b1, 8'b0111_0001, 1'b0, 1'b1};
        rows[4] = '{1, 1'b0, 8'h00, 1'b0, 1'b0};
        rows[5] = '{6, 1'b1, 8'h5a, 1'b1, 1'b0};
        rows[6] = '{10, 1'b0, 8'b1001_1100, 1'b0, 1'b1};

        repeat (5) clock_cycle();
        reset <= 1'b0;
        clock_cycle();
        assert (!pre_rd && !post_wr && !busy && !mem_full) else begin
            $display("error %0t: outputs not idle after reset", $time);
            errors++;
        end

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            r = rows[i];
            err_mark = errors;
            bp = r.bp_pattern;
            if (r.abort) begin
                start_capture(mem_words);
                pulse_write_done();
                wait_words(2);  // readback under way
            end
            start_capture(r.count);
            if (!r.done_late)
                pulse_write_done();
            wait_feed_done();
            if (r.done_late)
                pulse_write_done();
            wait_idle();
            n_exp = (r.count > mem_words) ? mem_words : r.count;
            assert (got == n_exp && exp_q.size() == 0) else begin
                $display("error %0t: %0d words read back, expected %0d", $time, got, n_exp);
                errors++;
            end
            assert (pre_q.size() == 0) else begin
                $display("error %0t: %0d samples left upstream", $time, pre_q.size());
                errors++;
            end
            assert (mem_full == r.exp_full) else begin
                $display("error %0t: mem_full is %0b, expected %0b", $time, mem_full, r.exp_full);
                errors++;
            end
            if (errors != err_mark)
                rows_failed++;
            $display("row %0d: %0d samples in, %0d words out, mem_full %0b, %s",
                     i, r.count, got, mem_full, (errors == err_mark) ? "ok" : "mismatch");
        end

        $display("rows failed %0d of %0d, failed checks %0d", rows_failed, n_rows, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/mem_if_pkg.sv
verilog/capture_pkg.sv
verilog/sample_writer.sv
verilog/app_mem.sv
verilog/sample_reader.sv
verilog/ddr_capture_top.sv
sim/ddr_capture_sva.sv
sim/tb_ddr_capture.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ddr_capture
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = STATUS: PASS
SOURCES   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
